//--- rtl/mcu_pkg.sv
////////////////////
// Shared widths, I/O register map and bus structs for the MCU peripherals
// Referenced by scoped name from every RTL module, compile it first
////////////////////

package mcu_pkg;

  localparam int unsigned WIDTH = 18;        // Processor word width

  typedef logic [WIDTH-1:0] word_t;          // I/O data word
  typedef logic [3:0]       io_addr_t;       // Register index in I/O space
  typedef logic [7:0]       byte_t;          // Serial data byte
  typedef logic [15:0]      baud_t;          // UART bit period in clocks
  typedef logic [3:0]       prescale_t;      // Flash sclk half-period minus one

  // Register map
  localparam io_addr_t ADDR_UART_DATA  = 4'd0;
  localparam io_addr_t ADDR_UART_STAT  = 4'd1;   // bit0 tx ready, bit1 rx full
  localparam io_addr_t ADDR_UART_RATE  = 4'd2;
  localparam io_addr_t ADDR_FLASH_DATA = 4'd3;
  localparam io_addr_t ADDR_FLASH_CTRL = 4'd4;   // bit0 ready, bit1 cs active
  localparam io_addr_t ADDR_FLASH_RATE = 4'd5;

  localparam baud_t     BAUD_RESET     = 16'd16;
  localparam prescale_t PRESCALE_RESET = 4'd0;

  // Processor request, one per clock
  typedef struct packed {
    logic     rd;        // Read strobe
    logic     wr;        // Write strobe
    io_addr_t addr;
    word_t    data;      // Write data
  } io_req_t;

  // Flash port setup
  typedef struct packed {
    logic      cs_active;   // Drives cs_n low
    prescale_t prescale;
  } flash_cfg_t;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  typedef enum logic {
    SPI_IDLE,
    SPI_SHIFT
  } spi_state_e;

endpackage

//--- rtl/uart_rx.sv
////////////////////
// UART 8N1 receiver with a two-flop rxd synchronizer
// Raises full on a good stop bit, rd clears it
////////////////////
`timescale 1ns/10ps

module uart_rx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rxd,       // Async serial input
  input  mcu_pkg::baud_t  baud,      // Clocks per bit
  input  logic            rd,        // Byte taken by processor
  output mcu_pkg::byte_t  rx_byte,   // Last good byte
  output logic            full       // Unread byte waiting
);

  logic                 rxd_meta;    // First sync stage
  logic                 rxd_s;       // Synchronized rxd
  mcu_pkg::uart_state_e state;
  mcu_pkg::baud_t       cnt;         // Clocks to next sample point
  logic [2:0]           bitn;        // Data bit index
  mcu_pkg::byte_t       shreg;       // Assembles LSB first
  logic                 sample;
  logic                 stop_ok;

  assign sample  = (cnt == '0);
  assign stop_ok = sample && (state == mcu_pkg::UART_STOP) && rxd_s;  // Framing good

  // Idle high so no false start bit out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_s    <= rxd_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= mcu_pkg::UART_IDLE;
      cnt   <= '0;
      bitn  <= '0;
      full  <= 1'b0;
    end else begin
      case (state)
        mcu_pkg::UART_IDLE: begin
          if (!rxd_s) begin                  // Start edge seen
            state <= mcu_pkg::UART_START;
            cnt   <= baud >> 1;              // Aim for mid start bit
          end
        end
        mcu_pkg::UART_START: begin
          if (!sample) cnt <= cnt - 1'b1;
          else if (rxd_s) state <= mcu_pkg::UART_IDLE;  // Glitch, not a start bit
          else begin
            state <= mcu_pkg::UART_DATA;
            cnt   <= baud - 1'b1;
            bitn  <= '0;
          end
        end
        mcu_pkg::UART_DATA: begin
          if (!sample) cnt <= cnt - 1'b1;
          else begin
            cnt  <= baud - 1'b1;
            bitn <= bitn + 1'b1;
            if (bitn == 3'd7) state <= mcu_pkg::UART_STOP;
          end
        end
        default: begin                       // Stop bit
          if (!sample) cnt <= cnt - 1'b1;
          else state <= mcu_pkg::UART_IDLE;  // Bad stop just drops the byte
        end
      endcase
      if (stop_ok) full <= 1'b1;             // New byte wins over a read
      else if (rd) full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sample && state == mcu_pkg::UART_DATA) shreg <= {rxd_s, shreg[7:1]};
    if (stop_ok) rx_byte <= shreg;           // Overwrites an unread byte
  end

endmodule

//--- rtl/uart_tx.sv
////////////////////
// UART 8N1 transmitter
// wr loads a byte while ready is high, txd drops on the next clock
////////////////////
`timescale 1ns/10ps

module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  mcu_pkg::baud_t  baud,      // Clocks per bit
  input  logic            wr,        // Send strobe
  input  mcu_pkg::byte_t  tx_byte,
  output logic            ready,     // Idle, next byte accepted
  output logic            txd
);

  mcu_pkg::uart_state_e state;
  mcu_pkg::baud_t       cnt;         // Clocks left in current bit
  logic [2:0]           bitn;
  logic [9:0]           frame;       // Stop, data, start; bit0 on the line
  logic                 tick;

  assign tick  = (cnt == '0);
  assign ready = (state == mcu_pkg::UART_IDLE);
  assign txd   = frame[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= mcu_pkg::UART_IDLE;
      cnt   <= '0;
      bitn  <= '0;
      frame <= '1;                           // Line idles high
    end else begin
      case (state)
        mcu_pkg::UART_IDLE: begin
          if (wr) begin
            frame <= {1'b1, tx_byte, 1'b0};
            cnt   <= baud - 1'b1;
            state <= mcu_pkg::UART_START;
          end
        end
        mcu_pkg::UART_START: begin
          if (!tick) cnt <= cnt - 1'b1;
          else begin
            frame <= {1'b1, frame[9:1]};
            cnt   <= baud - 1'b1;
            bitn  <= '0;
            state <= mcu_pkg::UART_DATA;
          end
        end
        mcu_pkg::UART_DATA: begin
          if (!tick) cnt <= cnt - 1'b1;
          else begin
            frame <= {1'b1, frame[9:1]};     // Next bit, LSB first
            cnt   <= baud - 1'b1;
            bitn  <= bitn + 1'b1;
            if (bitn == 3'd7) state <= mcu_pkg::UART_STOP;
          end
        end
        default: begin
          if (!tick) cnt <= cnt - 1'b1;
          else begin
            frame <= {1'b1, frame[9:1]};     // All ones again
            state <= mcu_pkg::UART_IDLE;     // 10 bit periods after wr
          end
        end
      endcase
    end
  end

endmodule

//--- rtl/spi_flash_port.sv
////////////////////
// Single-lane SPI flash byte shifter, MSB first on qdo[0], reads qdi[1]
// sclk half-period is prescale+1 clocks, idles high
////////////////////
`timescale 1ns/10ps

module spi_flash_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mcu_pkg::flash_cfg_t  cfg,
  input  logic                 wr,        // Start a byte transfer
  input  mcu_pkg::byte_t       tx_byte,
  output logic                 ready,     // Idle
  output mcu_pkg::byte_t       rx_byte,   // Last byte shifted in
  output logic                 sclk,
  output logic                 cs_n,
  input  logic [3:0]           qdi,
  output logic [3:0]           qdo,
  output logic [3:0]           oe         // Output enables for qdo
);

  mcu_pkg::spi_state_e state;
  mcu_pkg::prescale_t  pcnt;         // Clocks to next sclk edge
  logic [3:0]          hcnt;         // Half-period count, 16 per byte
  logic                sclk_q;
  logic                mosi;
  mcu_pkg::byte_t      tx_sr;
  mcu_pkg::byte_t      rx_sr;
  logic                half;         // sclk toggles this clock
  logic                fall;
  logic                rise;

  assign half = (state == mcu_pkg::SPI_SHIFT) && (pcnt == '0);
  assign fall = half && sclk_q;      // High going low, drive data
  assign rise = half && !sclk_q;     // Low going high, sample data

  assign ready = (state == mcu_pkg::SPI_IDLE);
  assign sclk  = sclk_q;
  assign cs_n  = ~cfg.cs_active;
  assign qdo   = {3'b000, mosi};     // Single lane only
  assign oe    = {3'b000, cfg.cs_active};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= mcu_pkg::SPI_IDLE;
      pcnt   <= '0;
      hcnt   <= '0;
      sclk_q <= 1'b1;
      mosi   <= 1'b0;
    end else begin
      case (state)
        mcu_pkg::SPI_IDLE: begin
          if (wr) begin
            state <= mcu_pkg::SPI_SHIFT;
            pcnt  <= cfg.prescale;
            hcnt  <= '0;
          end
        end
        default: begin
          if (!half) pcnt <= pcnt - 1'b1;
          else begin
            pcnt   <= cfg.prescale;
            sclk_q <= ~sclk_q;
            hcnt   <= hcnt + 1'b1;
            if (fall) mosi <= tx_sr[7];
            if (hcnt == 4'd15) state <= mcu_pkg::SPI_IDLE;  // Ends on a rising edge
          end
        end
      endcase
    end
  end

  // Shift data, loaded only when idle
  always_ff @(posedge clk) begin
    if (ready && wr) tx_sr <= tx_byte;
    else if (fall) tx_sr <= {tx_sr[6:0], 1'b0};
    if (rise) rx_sr <= {rx_sr[6:0], qdi[1]};
    if (rise && hcnt == 4'd15) rx_byte <= {rx_sr[6:0], qdi[1]};  // Eighth bit in
  end

endmodule

//--- rtl/io_regs.sv
////////////////////
// I/O register file: decodes processor strobes, holds UART and flash setup
// Write strobes to busy units are dropped, reads land in dout a clock later
////////////////////
`timescale 1ns/10ps

module io_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mcu_pkg::io_req_t     req,
  output mcu_pkg::word_t       dout,        // Held until next read
  output mcu_pkg::baud_t       baud,
  output mcu_pkg::flash_cfg_t  flash_cfg,
  output logic                 tx_wr,
  output mcu_pkg::byte_t       tx_byte,
  input  logic                 tx_ready,
  input  mcu_pkg::byte_t       rx_byte,
  input  logic                 rx_full,
  output logic                 rx_rd,
  output logic                 f_wr,
  output mcu_pkg::byte_t       f_byte,
  input  logic                 f_ready,
  input  mcu_pkg::byte_t       f_rx_byte
);

  mcu_pkg::word_t rd_data;           // Read mux output

  // Strobes to the serial units
  assign tx_wr   = req.wr && (req.addr == mcu_pkg::ADDR_UART_DATA) && tx_ready;
  assign tx_byte = req.data[7:0];
  assign rx_rd   = req.rd && (req.addr == mcu_pkg::ADDR_UART_DATA);   // Clears full
  assign f_wr    = req.wr && (req.addr == mcu_pkg::ADDR_FLASH_DATA) && f_ready;
  assign f_byte  = req.data[7:0];

  always_comb begin
    rd_data = '0;                    // Unmapped reads as zero
    case (req.addr)
      mcu_pkg::ADDR_UART_DATA:  rd_data[7:0]  = rx_byte;
      mcu_pkg::ADDR_UART_STAT:  rd_data[1:0]  = {rx_full, tx_ready};
      mcu_pkg::ADDR_UART_RATE:  rd_data[15:0] = baud;
      mcu_pkg::ADDR_FLASH_DATA: rd_data[7:0]  = f_rx_byte;
      mcu_pkg::ADDR_FLASH_CTRL: rd_data[1:0]  = {flash_cfg.cs_active, f_ready};
      mcu_pkg::ADDR_FLASH_RATE: rd_data[3:0]  = flash_cfg.prescale;
      default:                  rd_data       = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud                <= mcu_pkg::BAUD_RESET;
      flash_cfg.cs_active <= 1'b0;
      flash_cfg.prescale  <= mcu_pkg::PRESCALE_RESET;
      dout                <= '0;
    end else begin
      if (req.wr) begin
        case (req.addr)
          mcu_pkg::ADDR_UART_RATE:  baud                <= req.data[15:0];
          mcu_pkg::ADDR_FLASH_CTRL: flash_cfg.cs_active <= req.data[0];
          mcu_pkg::ADDR_FLASH_RATE: flash_cfg.prescale  <= req.data[3:0];
          default: ;                 // Data writes go out as strobes
        endcase
      end
      if (req.rd) dout <= rd_data;
    end
  end

endmodule

//--- rtl/mcu_io.sv
////////////////////
// MCU peripheral top: processor I/O bus to UART and SPI flash pins
// Clock and conditioned reset come from the surrounding I/O ring
////////////////////
`timescale 1ns/10ps

module mcu_io (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                io_rd,      // I/O read strobe
  input  logic                io_wr,      // I/O write strobe
  input  mcu_pkg::io_addr_t   io_addr,
  input  mcu_pkg::word_t      io_din,
  output mcu_pkg::word_t      io_dout,
  input  logic                rxd,        // Async UART input
  output logic                txd,
  output logic                sclk,       // Fclk / (2 * (prescale + 1))
  output logic                cs_n,
  input  logic [3:0]          qdi,
  output logic [3:0]          qdo,
  output logic [3:0]          oe
);

  mcu_pkg::io_req_t    req;
  mcu_pkg::baud_t      baud;
  mcu_pkg::flash_cfg_t flash_cfg;
  logic                tx_wr;
  mcu_pkg::byte_t      tx_byte;
  logic                tx_ready;
  mcu_pkg::byte_t      rx_byte;
  logic                rx_full;
  logic                rx_rd;
  logic                f_wr;
  mcu_pkg::byte_t      f_byte;
  logic                f_ready;
  mcu_pkg::byte_t      f_rx_byte;

  assign req = '{rd: io_rd, wr: io_wr, addr: io_addr, data: io_din};

  uart_rx i_uart_rx (
    .clk(clk), .rst_n(rst_n), .rxd(rxd), .baud(baud),
    .rd(rx_rd), .rx_byte(rx_byte), .full(rx_full)
  );

  io_regs i_io_regs (
    .clk(clk), .rst_n(rst_n), .req(req), .dout(io_dout),
    .baud(baud), .flash_cfg(flash_cfg),
    .tx_wr(tx_wr), .tx_byte(tx_byte), .tx_ready(tx_ready),
    .rx_byte(rx_byte), .rx_full(rx_full), .rx_rd(rx_rd),
    .f_wr(f_wr), .f_byte(f_byte), .f_ready(f_ready), .f_rx_byte(f_rx_byte)
  );

  uart_tx i_uart_tx (
    .clk(clk), .rst_n(rst_n), .baud(baud), .wr(tx_wr),
    .tx_byte(tx_byte), .ready(tx_ready), .txd(txd)
  );

  spi_flash_port i_spi_flash_port (
    .clk(clk), .rst_n(rst_n), .cfg(flash_cfg), .wr(f_wr), .tx_byte(f_byte),
    .ready(f_ready), .rx_byte(f_rx_byte), .sclk(sclk), .cs_n(cs_n),
    .qdi(qdi), .qdo(qdo), .oe(oe)
  );

endmodule

//--- testbench/tb_clock.sv
////////////////////
// Free-running testbench clock, 20 ns period
////////////////////
`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  localparam int HALF_NS = 10;   // Half of the 20 ns period

  initial clk = 1'b0;
  always #(HALF_NS) clk = ~clk;

endmodule

//--- testbench/tb_mcu_io.sv
////////////////////
// Testbench for mcu_io with the UART looped back and a flash slave model on the SPI pins
// Register reads are checked against a model of the register rules
////////////////////
`timescale 1ns/10ps

module tb_mcu_io;

  localparam int CLK_NS          = 20;
  localparam int UART_FRAME_CLKS = 23 * 10;   // Slowest baud in use
  localparam int FLASH_XFER_CLKS = 16 * 4;    // Prescale 3
  localparam int WATCHDOG_NS = 2 * (40 * UART_FRAME_CLKS + 40 * FLASH_XFER_CLKS) * CLK_NS;

  logic               clk;
  logic               rst_n;
  logic               io_rd;
  logic               io_wr;
  mcu_pkg::io_addr_t  io_addr;
  mcu_pkg::word_t     io_din;
  mcu_pkg::word_t     io_dout;
  logic               txd;                    // Also fed back as rxd
  logic               sclk;
  logic               cs_n;
  logic [3:0]         qdi;
  logic [3:0]         qdo;
  logic [3:0]         oe;

  int                 errors = 0;
  mcu_pkg::baud_t     m_baud = mcu_pkg::BAUD_RESET;        // Register model
  mcu_pkg::prescale_t m_prescale = mcu_pkg::PRESCALE_RESET;
  logic               m_cs = 1'b0;
  mcu_pkg::byte_t     m_rx_byte = '0;
  mcu_pkg::byte_t     m_f_byte = '0;
  mcu_pkg::byte_t     m_last_sent = '0;       // Slave answers ~0 first
  mcu_pkg::byte_t     slave_q[$];             // Bytes seen by the flash slave
  mcu_pkg::byte_t     slave_sr = '0;
  mcu_pkg::byte_t     resp_sr = 8'hff;
  int                 slave_cnt = 0;
  logic               slave_bit = 1'b0;

  tb_clock i_tb_clock (.clk(clk));

  mcu_io i_mcu_io (
    .clk(clk), .rst_n(rst_n), .io_rd(io_rd), .io_wr(io_wr), .io_addr(io_addr),
    .io_din(io_din), .io_dout(io_dout), .rxd(txd), .txd(txd), .sclk(sclk),
    .cs_n(cs_n), .qdi(qdi), .qdo(qdo), .oe(oe)
  );

  // Flash slave samples on sclk rise and answers on sclk fall
  assign qdi = {2'b00, slave_bit, 1'b0};      // Reply on lane 1 only

  always @(sclk) begin
    if (rst_n && !cs_n) begin
      if (sclk) begin
        slave_sr = {slave_sr[6:0], qdo[0]};   // MSB first
        slave_cnt++;
        if (slave_cnt == 8) begin
          slave_q.push_back(slave_sr);
          resp_sr = ~slave_sr;                // Reply for the next byte
          slave_cnt = 0;
        end
      end else begin
        slave_bit <= resp_sr[7];
        resp_sr = {resp_sr[6:0], 1'b0};
      end
    end
  end

  // Expected read data with both serial units idle and nothing received
  function automatic mcu_pkg::word_t expect_read(input mcu_pkg::io_addr_t addr);
    mcu_pkg::word_t v;
    v = '0;
    case (addr)
      mcu_pkg::ADDR_UART_DATA:  v[7:0]  = m_rx_byte;
      mcu_pkg::ADDR_UART_STAT:  v[1:0]  = 2'b01;          // Ready and not full
      mcu_pkg::ADDR_UART_RATE:  v[15:0] = m_baud;
      mcu_pkg::ADDR_FLASH_DATA: v[7:0]  = m_f_byte;
      mcu_pkg::ADDR_FLASH_CTRL: v[1:0]  = {m_cs, 1'b1};
      mcu_pkg::ADDR_FLASH_RATE: v[3:0]  = m_prescale;
      default:                  v       = '0;             // Unmapped
    endcase
    return v;
  endfunction

  task automatic compare_value(input string name, input mcu_pkg::word_t exp,
                               input mcu_pkg::word_t act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic drive_write(input mcu_pkg::io_addr_t addr, input mcu_pkg::word_t data);
    @(posedge clk);
    io_wr   <= 1'b1;
    io_addr <= addr;
    io_din  <= data;
    @(posedge clk);                           // Write lands here
    io_wr   <= 1'b0;
  endtask

  task automatic drive_read(input mcu_pkg::io_addr_t addr, output mcu_pkg::word_t data);
    @(posedge clk);
    io_rd   <= 1'b1;
    io_addr <= addr;
    @(posedge clk);
    io_rd   <= 1'b0;
    @(negedge clk);                           // io_dout settled
    data = io_dout;
  endtask

  task automatic read_and_check(input string name, input mcu_pkg::io_addr_t addr);
    mcu_pkg::word_t val;
    drive_read(addr, val);
    compare_value(name, expect_read(addr), val);
  endtask

  // Polls a status bit until it reads set
  task automatic wait_for_bit(input mcu_pkg::io_addr_t addr, input int idx);
    mcu_pkg::word_t val;
    val = '0;
    while (!val[idx]) drive_read(addr, val);
  endtask

  task automatic check_slave_byte(input mcu_pkg::byte_t exp);
    mcu_pkg::byte_t got;
    if (slave_q.size() == 0) begin
      errors++;
      $display("flash slave received nothing where byte %h was sent", exp);
    end else begin
      got = slave_q.pop_front();
      compare_value("flash slave byte", mcu_pkg::word_t'(exp), mcu_pkg::word_t'(got));
    end
  endtask

  // Waits for the transfer to end and checks both directions
  task automatic finish_flash(input mcu_pkg::byte_t sent);
    wait_for_bit(mcu_pkg::ADDR_FLASH_CTRL, 0);
    check_slave_byte(sent);
    m_f_byte    = ~m_last_sent;               // Slave echoes ~previous byte
    m_last_sent = sent;
    read_and_check("flash readback", mcu_pkg::ADDR_FLASH_DATA);
  endtask

  initial begin
    mcu_pkg::word_t val;
    mcu_pkg::byte_t b;
    time            t_rise;
    void'($urandom(11869));
    rst_n   = 1'b0;
    io_rd   = 1'b0;
    io_wr   = 1'b0;
    io_addr = '0;
    io_din  = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_value("reset txd", mcu_pkg::word_t'(1), mcu_pkg::word_t'(txd));
    compare_value("reset sclk", mcu_pkg::word_t'(1), mcu_pkg::word_t'(sclk));
    compare_value("reset cs_n", mcu_pkg::word_t'(1), mcu_pkg::word_t'(cs_n));
    compare_value("reset oe", '0, mcu_pkg::word_t'(oe));
    read_and_check("reset uart stat", mcu_pkg::ADDR_UART_STAT);
    read_and_check("reset flash ctrl", mcu_pkg::ADDR_FLASH_CTRL);
    read_and_check("reset uart rate", mcu_pkg::ADDR_UART_RATE);
    read_and_check("reset flash rate", mcu_pkg::ADDR_FLASH_RATE);

    // Register readback where the upper write bits are dropped
    drive_write(mcu_pkg::ADDR_UART_RATE, 18'h2a5c3);
    m_baud = 16'ha5c3;
    read_and_check("uart rate readback", mcu_pkg::ADDR_UART_RATE);
    m_prescale = mcu_pkg::prescale_t'($urandom_range(3, 0));
    drive_write(mcu_pkg::ADDR_FLASH_RATE, mcu_pkg::word_t'(m_prescale));
    read_and_check("flash rate readback", mcu_pkg::ADDR_FLASH_RATE);
    read_and_check("unmapped read", 4'd9);

    // UART loopback at two bit rates
    for (int bi = 0; bi < 2; bi++) begin
      m_baud = (bi == 0) ? 16'd16 : 16'd23;
      wait_for_bit(mcu_pkg::ADDR_UART_STAT, 0);
      drive_write(mcu_pkg::ADDR_UART_RATE, mcu_pkg::word_t'(m_baud));
      repeat (20) begin
        b = mcu_pkg::byte_t'($urandom);
        wait_for_bit(mcu_pkg::ADDR_UART_STAT, 0);
        drive_write(mcu_pkg::ADDR_UART_DATA, mcu_pkg::word_t'(b));
        wait_for_bit(mcu_pkg::ADDR_UART_STAT, 1);      // Byte back on rxd
        m_rx_byte = b;
        read_and_check("uart loopback byte", mcu_pkg::ADDR_UART_DATA);
        drive_read(mcu_pkg::ADDR_UART_STAT, val);
        compare_value("uart full clear", '0, mcu_pkg::word_t'(val[1]));
      end
    end

    // Second UART write while busy
    b = mcu_pkg::byte_t'($urandom);
    wait_for_bit(mcu_pkg::ADDR_UART_STAT, 0);
    drive_write(mcu_pkg::ADDR_UART_DATA, mcu_pkg::word_t'(b));
    drive_write(mcu_pkg::ADDR_UART_DATA, mcu_pkg::word_t'(~b));
    wait_for_bit(mcu_pkg::ADDR_UART_STAT, 1);
    m_rx_byte = b;
    read_and_check("uart busy write dropped", mcu_pkg::ADDR_UART_DATA);
    wait_for_bit(mcu_pkg::ADDR_UART_STAT, 0);
    drive_read(mcu_pkg::ADDR_UART_STAT, val);
    compare_value("uart no extra frame", '0, mcu_pkg::word_t'(val[1]));

    // Flash chip select and transfers
    drive_write(mcu_pkg::ADDR_FLASH_CTRL, mcu_pkg::word_t'(1));
    m_cs = 1'b1;
    @(negedge clk);
    compare_value("cs_n active", '0, mcu_pkg::word_t'(cs_n));
    compare_value("oe active", mcu_pkg::word_t'(4'b0001), mcu_pkg::word_t'(oe));
    read_and_check("flash ctrl active", mcu_pkg::ADDR_FLASH_CTRL);
    repeat (20) begin
      m_prescale = mcu_pkg::prescale_t'($urandom_range(3, 0));
      drive_write(mcu_pkg::ADDR_FLASH_RATE, mcu_pkg::word_t'(m_prescale));
      b = mcu_pkg::byte_t'($urandom);
      drive_write(mcu_pkg::ADDR_FLASH_DATA, mcu_pkg::word_t'(b));
      finish_flash(b);
    end

    // sclk period measured over one transfer
    m_prescale = 4'd3;
    drive_write(mcu_pkg::ADDR_FLASH_RATE, mcu_pkg::word_t'(m_prescale));
    b = mcu_pkg::byte_t'($urandom);
    drive_write(mcu_pkg::ADDR_FLASH_DATA, mcu_pkg::word_t'(b));
    @(posedge sclk);
    t_rise = $time;
    @(posedge sclk);
    compare_value("sclk period clocks", mcu_pkg::word_t'(2 * (m_prescale + 1)),
                  mcu_pkg::word_t'(($time - t_rise) / CLK_NS));
    finish_flash(b);

    // Flash write during a transfer
    b = mcu_pkg::byte_t'($urandom);
    drive_write(mcu_pkg::ADDR_FLASH_DATA, mcu_pkg::word_t'(b));
    drive_write(mcu_pkg::ADDR_FLASH_DATA, mcu_pkg::word_t'(~b));
    finish_flash(b);
    read_and_check("flash idle after busy write", mcu_pkg::ADDR_FLASH_CTRL);
    repeat (FLASH_XFER_CLKS) @(posedge clk);  // One whole transfer at prescale 3
    compare_value("flash busy write dropped", '0, mcu_pkg::word_t'(slave_q.size()));

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) $display("Test OK");
    else $display("Test FAILED");
    $finish;
  end

  // Ends a stuck run after twice the slowest frames and transfers
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, tests unfinished, %0d errors", WATCHDOG_NS, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- files.f
rtl/mcu_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/spi_flash_port.sv
rtl/io_regs.sv
rtl/mcu_io.sv
testbench/tb_clock.sv
testbench/tb_mcu_io.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mcu_io testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module tb_mcu_io
out=$(./obj_dir/Vtb_mcu_io)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
